//--- include/lsu_mem_cfg.svh
`ifndef LSU_MEM_CFG_SVH
`define LSU_MEM_CFG_SVH

// data and address width of the core
`define XLEN 64

// word-index bits of the data memory, 1024 doublewords
`define DMEM_AW 10

// width of the response latency setting
`define LAT_W 4

// latency after reset
`define LAT_RESET 2

// width of the access counters
`define CNT_W 32

`endif

//--- design/lsu_mem_pkg.sv
`default_nettype none

`include "lsu_mem_cfg.svh"

package lsu_mem_pkg;

    // data or address word
    typedef logic [`XLEN-1:0] xlen_t;

    // funct3 memory op
    typedef logic [2:0] memop_t;

    // access size, log2 of the byte count
    typedef logic [2:0] size_t;

    // byte mask relative to the access address
    typedef logic [7:0] mask_t;

    // sram response latency
    typedef logic [`LAT_W-1:0] lat_t;

    // access counter value
    typedef logic [`CNT_W-1:0] cnt_t;

    // configuration register offset
    typedef logic [1:0] cfg_addr_t;

    // load ops, stores reuse 0..3 for sb/sh/sw/sd
    localparam memop_t MEMOP_LB  = 3'd0;
    localparam memop_t MEMOP_LH  = 3'd1;
    localparam memop_t MEMOP_LW  = 3'd2;
    localparam memop_t MEMOP_LD  = 3'd3;
    localparam memop_t MEMOP_LBU = 3'd4;
    localparam memop_t MEMOP_LHU = 3'd5;
    localparam memop_t MEMOP_LWU = 3'd6;

    // register map of mem_ctrl_regs
    localparam cfg_addr_t REG_LAT    = 2'd0;
    localparam cfg_addr_t REG_LOADS  = 2'd1;
    localparam cfg_addr_t REG_STORES = 2'd2;
    localparam cfg_addr_t REG_FAULTS = 2'd3;

endpackage

`default_nettype wire

//--- design/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu
    import lsu_mem_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n_i,

    // core side
    input  wire logic   rden_i,
    input  wire logic   wren_i,
    input  wire memop_t memop_i,
    input  wire xlen_t  addr_i,
    input  wire xlen_t  wr_data_i,
    output xlen_t       ls_res_o,
    output logic        ls_done_o,
    output logic        ls_fault_o,

    // sram side
    output xlen_t       sram_addr_o,
    output logic        sram_rd_en_o,
    output logic        sram_wr_en_o,
    output xlen_t       sram_wr_data_o,
    output mask_t       sram_wr_mask_o,
    output size_t       sram_size_o,
    input  wire logic   sram_rd_valid_i,
    input  wire logic   sram_wr_ok_i,
    input  wire xlen_t  sram_rd_data_i
);

    size_t       acc_size;
    mask_t       acc_mask;
    logic        access;
    logic        misaligned;
    xlen_t       lane_data;
    logic [7:0]  rd_b;
    logic [15:0] rd_h;
    logic [31:0] rd_w;

    assign access = rden_i | wren_i;

    // funct3[1:0] gives the size for loads and stores alike
    always_comb begin
        case (memop_i[1:0])
            2'd0: begin
                acc_size = 3'd0;
                acc_mask = 8'b0000_0001;
            end
            2'd1: begin
                acc_size = 3'd1;
                acc_mask = 8'b0000_0011;
            end
            2'd2: begin
                acc_size = 3'd2;
                acc_mask = 8'b0000_1111;
            end
            default: begin
                acc_size = 3'd3;
                acc_mask = 8'b1111_1111;
            end
        endcase
    end

    // natural alignment, low address bits below the size must be zero
    always_comb begin
        case (acc_size)
            3'd1:    misaligned = addr_i[0];
            3'd2:    misaligned = |addr_i[1:0];
            3'd3:    misaligned = |addr_i[2:0];
            default: misaligned = 1'b0;
        endcase
    end

    // misaligned access never reaches the memory
    assign sram_rd_en_o   = rden_i & ~misaligned;
    assign sram_wr_en_o   = wren_i & ~misaligned;
    assign sram_addr_o    = addr_i;
    assign sram_wr_data_o = wr_data_i;
    assign sram_wr_mask_o = acc_mask;
    assign sram_size_o    = acc_size;

    // refused access completes at once with the fault flag
    assign ls_fault_o = access & misaligned;
    assign ls_done_o  = (sram_rd_en_o & sram_rd_valid_i)
                      | (sram_wr_en_o & sram_wr_ok_i)
                      | ls_fault_o;

    // bring the addressed lane down to bit 0
    assign lane_data = sram_rd_data_i >> {addr_i[2:0], 3'b000};
    assign rd_b      = lane_data[7:0];
    assign rd_h      = lane_data[15:0];
    assign rd_w      = lane_data[31:0];

    // sign or zero extension per op
    always_comb begin
        ls_res_o = '0;
        if (rden_i) begin
            case (memop_i)
                MEMOP_LB:  ls_res_o = xlen_t'($signed(rd_b));
                MEMOP_LH:  ls_res_o = xlen_t'($signed(rd_h));
                MEMOP_LW:  ls_res_o = xlen_t'($signed(rd_w));
                MEMOP_LD:  ls_res_o = sram_rd_data_i;
                MEMOP_LBU: ls_res_o = xlen_t'(rd_b);
                MEMOP_LHU: ls_res_o = xlen_t'(rd_h);
                MEMOP_LWU: ls_res_o = xlen_t'(rd_w);
                default:   ls_res_o = '0;
            endcase
        end
    end

    // requester keeps the whole request steady while it waits for done
    property p_req_held;
        @(posedge clk) disable iff (!rst_n_i)
            (access && !ls_done_o) |=>
                $stable({rden_i, wren_i, memop_i}) &&
                $stable(addr_i) && $stable(wr_data_i);
    endproperty
    a_req_held: assert property (p_req_held);

    // one direction per request
    a_one_dir: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(rden_i && wren_i)
    );

endmodule

`default_nettype wire

//--- design/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_mem_cfg.svh"

module data_sram
    import lsu_mem_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    input  wire xlen_t sram_addr_i,
    input  wire logic  sram_rd_en_i,
    input  wire logic  sram_wr_en_i,
    input  wire xlen_t sram_wr_data_i,
    input  wire mask_t sram_wr_mask_i,
    input  wire size_t sram_size_i,
    input  wire lat_t  lat_cfg_i,
    output logic       sram_rd_valid_o,
    output logic       sram_wr_ok_o,
    output xlen_t      sram_rd_data_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } sram_state_e;

    localparam int unsigned DEPTH = 1 << `DMEM_AW;

    xlen_t               mem [DEPTH];
    xlen_t               rd_data_q;
    sram_state_e         state_q;
    sram_state_e         state_d;
    lat_t                wait_q;
    lat_t                wait_d;
    logic                op_wr_q;
    logic                req;
    logic [`DMEM_AW-1:0] word_idx;
    logic [2:0]          byte_off;
    logic [15:0]         mask_wide;
    mask_t               byte_en;
    xlen_t               wr_data_sh;
    logic [3:0]          span_end;

    assign req = sram_rd_en_i | sram_wr_en_i;

    // doubleword index, upper address bits wrap
    assign word_idx = sram_addr_i[`DMEM_AW+2:3];
    assign byte_off = sram_addr_i[2:0];

    // mask and data move up to the addressed bytes
    assign mask_wide  = {8'b0, sram_wr_mask_i} << byte_off;
    assign byte_en    = mask_wide[7:0];
    assign wr_data_sh = sram_wr_data_i << {byte_off, 3'b000};

    // latency fsm, lat_cfg_i sampled only when a request starts
    always_comb begin
        state_d = state_q;
        wait_d  = wait_q;
        case (state_q)
            ST_IDLE: begin
                if (req) begin
                    wait_d  = lat_cfg_i;
                    state_d = (lat_cfg_i == '0) ? ST_RESP : ST_WAIT;
                end
            end
            ST_WAIT: begin
                // last wait cycle when the count reaches one
                if (wait_q == lat_t'(1)) begin
                    state_d = ST_RESP;
                end else begin
                    wait_d = wait_q - lat_t'(1);
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            wait_q  <= '0;
            op_wr_q <= 1'b0;
        end else begin
            state_q <= state_d;
            wait_q  <= wait_d;
            // direction of the request being served
            if (state_q == ST_IDLE && req) begin
                op_wr_q <= sram_wr_en_i;
            end
        end
    end

    // read data captured on the way into RESP
    always_ff @(posedge clk) begin
        if (state_d == ST_RESP && state_q != ST_RESP) begin
            rd_data_q <= mem[word_idx];
        end
    end

    // write lands on the edge that ends the RESP cycle
    always_ff @(posedge clk) begin
        if (state_q == ST_RESP && op_wr_q) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][b*8 +: 8] <= wr_data_sh[b*8 +: 8];
                end
            end
        end
    end

    assign sram_rd_valid_o = (state_q == ST_RESP) && !op_wr_q;
    assign sram_wr_ok_o    = (state_q == ST_RESP) && op_wr_q;
    assign sram_rd_data_o  = rd_data_q;

    // bytes of a write stay within one doubleword
    assign span_end = {1'b0, byte_off} + (4'd1 << sram_size_i[1:0]);

    a_mask_inside: assert property (
        @(posedge clk) disable iff (!rst_n_i)
            sram_wr_en_i |-> !sram_size_i[2] && (span_end <= 4'd8) &&
                             (mask_wide[15:8] == '0)
    );

    a_resp_excl: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(sram_rd_valid_o && sram_wr_ok_o)
    );

endmodule

`default_nettype wire

//--- design/mem_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_mem_cfg.svh"

module mem_ctrl_regs
    import lsu_mem_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n_i,
    input  wire logic      cfg_wr_i,
    input  wire cfg_addr_t cfg_addr_i,
    input  wire cnt_t      cfg_wdata_i,
    input  wire logic      ls_done_i,
    input  wire logic      rden_i,
    input  wire logic      wren_i,
    input  wire logic      ls_fault_i,
    output cnt_t           cfg_rdata_o,
    output lat_t           lat_cfg_o
);

    lat_t lat_q;
    cnt_t loads_q;
    cnt_t stores_q;
    cnt_t faults_q;
    logic load_evt;
    logic store_evt;
    logic fault_evt;

    // clear wins over a same-cycle event, count sticks at all ones
    function automatic cnt_t cnt_next(input cnt_t cur, input logic clr, input logic inc);
        cnt_t nxt;
        nxt = cur;
        if (clr) begin
            nxt = '0;
        end else if (inc && cur != '1) begin
            nxt = cur + cnt_t'(1);
        end
        return nxt;
    endfunction

    // completed accesses, faulted ones counted apart
    assign load_evt  = ls_done_i & rden_i & ~ls_fault_i;
    assign store_evt = ls_done_i & wren_i & ~ls_fault_i;
    assign fault_evt = ls_done_i & ls_fault_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lat_q    <= lat_t'(`LAT_RESET);
            loads_q  <= '0;
            stores_q <= '0;
            faults_q <= '0;
        end else begin
            if (cfg_wr_i && cfg_addr_i == REG_LAT) begin
                lat_q <= lat_t'(cfg_wdata_i);
            end
            loads_q  <= cnt_next(loads_q, cfg_wr_i && cfg_addr_i == REG_LOADS, load_evt);
            stores_q <= cnt_next(stores_q, cfg_wr_i && cfg_addr_i == REG_STORES, store_evt);
            faults_q <= cnt_next(faults_q, cfg_wr_i && cfg_addr_i == REG_FAULTS, fault_evt);
        end
    end

    // register read, no wait state
    always_comb begin
        case (cfg_addr_i)
            REG_LAT:    cfg_rdata_o = cnt_t'(lat_q);
            REG_LOADS:  cfg_rdata_o = loads_q;
            REG_STORES: cfg_rdata_o = stores_q;
            default:    cfg_rdata_o = faults_q;
        endcase
    end

    assign lat_cfg_o = lat_q;

    // a done belongs to exactly one direction
    a_done_dir: assert property (
        @(posedge clk) disable iff (!rst_n_i) ls_done_i |-> (rden_i ^ wren_i)
    );

endmodule

`default_nettype wire

//--- design/lsu_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_top
    import lsu_mem_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n_i,

    // core port
    input  wire logic      rden_i,
    input  wire logic      wren_i,
    input  wire memop_t    memop_i,
    input  wire xlen_t     addr_i,
    input  wire xlen_t     wr_data_i,
    output xlen_t          ls_res_o,
    output logic           ls_done_o,
    output logic           ls_fault_o,

    // configuration port
    input  wire logic      cfg_wr_i,
    input  wire cfg_addr_t cfg_addr_i,
    input  wire cnt_t      cfg_wdata_i,
    output cnt_t           cfg_rdata_o
);

    // lsu to sram
    xlen_t sram_addr;
    logic  sram_rd_en;
    logic  sram_wr_en;
    xlen_t sram_wr_data;
    mask_t sram_wr_mask;
    size_t sram_size;

    // sram back to lsu
    logic  sram_rd_valid;
    logic  sram_wr_ok;
    xlen_t sram_rd_data;

    lat_t  lat_cfg;

    lsu lsu_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .rden_i          (rden_i),
        .wren_i          (wren_i),
        .memop_i         (memop_i),
        .addr_i          (addr_i),
        .wr_data_i       (wr_data_i),
        .ls_res_o        (ls_res_o),
        .ls_done_o       (ls_done_o),
        .ls_fault_o      (ls_fault_o),
        .sram_addr_o     (sram_addr),
        .sram_rd_en_o    (sram_rd_en),
        .sram_wr_en_o    (sram_wr_en),
        .sram_wr_data_o  (sram_wr_data),
        .sram_wr_mask_o  (sram_wr_mask),
        .sram_size_o     (sram_size),
        .sram_rd_valid_i (sram_rd_valid),
        .sram_wr_ok_i    (sram_wr_ok),
        .sram_rd_data_i  (sram_rd_data)
    );

    data_sram data_sram_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .sram_addr_i     (sram_addr),
        .sram_rd_en_i    (sram_rd_en),
        .sram_wr_en_i    (sram_wr_en),
        .sram_wr_data_i  (sram_wr_data),
        .sram_wr_mask_i  (sram_wr_mask),
        .sram_size_i     (sram_size),
        .lat_cfg_i       (lat_cfg),
        .sram_rd_valid_o (sram_rd_valid),
        .sram_wr_ok_o    (sram_wr_ok),
        .sram_rd_data_o  (sram_rd_data)
    );

    // counters watch the core port directly
    mem_ctrl_regs mem_ctrl_regs_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cfg_wr_i    (cfg_wr_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .ls_done_i   (ls_done_o),
        .rden_i      (rden_i),
        .wren_i      (wren_i),
        .ls_fault_i  (ls_fault_o),
        .cfg_rdata_o (cfg_rdata_o),
        .lat_cfg_o   (lat_cfg)
    );

endmodule

`default_nettype wire

//--- verification/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    // free running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset held low over the first cycles, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/tb_lsu_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_mem_cfg.svh"

module tb_lsu_mem
    import lsu_mem_pkg::*;
();

    // worst case of 86 core accesses at 15 wait cycles plus request and response
    localparam int ACCESSES   = 86;
    localparam int MAX_CYCLES = ACCESSES * (15 + 2) + 300;
    localparam int WAIT_LIMIT = 20;
    localparam int WORDS      = 1 << `DMEM_AW;

    logic clk, rst_n, rden, wren, cfg_wr, ls_done, ls_fault;
    memop_t memop;
    xlen_t addr, wr_data, ls_res;
    cfg_addr_t cfg_addr;
    cnt_t cfg_wdata, cfg_rdata;
    int errors, tests_run, tests_failed, cycle_cnt;
    int loads_tally, stores_tally, faults_tally;

    // byte image of the data memory
    logic [7:0] model_mem [0:(8 << `DMEM_AW) - 1];

    clk_gen #(.PERIOD_NS(40), .RST_CYCLES(4)) clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

    lsu_mem_top lsu_mem_top_i (
        .clk(clk), .rst_n_i(rst_n), .rden_i(rden), .wren_i(wren), .memop_i(memop),
        .addr_i(addr), .wr_data_i(wr_data), .ls_res_o(ls_res), .ls_done_o(ls_done),
        .ls_fault_o(ls_fault), .cfg_wr_i(cfg_wr), .cfg_addr_i(cfg_addr),
        .cfg_wdata_i(cfg_wdata), .cfg_rdata_o(cfg_rdata)
    );

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // little endian store of 1, 2, 4 or 8 bytes per funct3[1:0]
    function automatic void model_store(input memop_t op, input xlen_t a, input xlen_t d);
        logic [`DMEM_AW+2:0] idx;
        idx = a[`DMEM_AW+2:0];
        for (int i = 0; i < (1 << op[1:0]); i++) begin
            model_mem[idx] = d[i*8 +: 8];
            idx = idx + 1'b1;
        end
    endfunction

    // signed ops copy the top bit of the loaded lane upward
    function automatic xlen_t model_load(input memop_t op, input xlen_t a);
        xlen_t raw;
        logic [`DMEM_AW+2:0] idx;
        raw = '0;
        idx = a[`DMEM_AW+2:0];
        for (int i = 0; i < (1 << op[1:0]); i++) begin
            raw[i*8 +: 8] = model_mem[idx];
            idx = idx + 1'b1;
        end
        case (op)
            MEMOP_LB: return {{56{raw[7]}}, raw[7:0]};
            MEMOP_LH: return {{48{raw[15]}}, raw[15:0]};
            MEMOP_LW: return {{32{raw[31]}}, raw[31:0]};
            default:  return raw;
        endcase
    endfunction

    // one request held until done and dropped on the next falling edge
    task automatic do_access(input logic is_wr, input memop_t op, input xlen_t a,
                             input xlen_t d, output xlen_t res, output logic fault);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        res = '0;
        fault = 1'b0;
        @(negedge clk);
        rden = ~is_wr;
        wren = is_wr;
        memop = op;
        addr = a;
        wr_data = d;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            if (ls_done) begin
                seen = 1'b1;
                res = ls_res;
                fault = ls_fault;
            end
        end
        if (!seen) begin
            $display("access at address %h got no done within %0d cycles", a, WAIT_LIMIT);
            errors++;
        end
        @(negedge clk);
        rden = 1'b0;
        wren = 1'b0;
    endtask

    task automatic store(input string name, input memop_t op, input xlen_t a, input xlen_t d);
        xlen_t res;
        logic fault;
        do_access(1'b1, op, a, d, res, fault);
        stores_tally++;
        check_bit({name, " fault"}, 1'b0, fault);
        model_store(op, a, d);
    endtask

    task automatic load_check(input string name, input memop_t op, input xlen_t a);
        xlen_t res;
        logic fault;
        do_access(1'b0, op, a, '0, res, fault);
        loads_tally++;
        check_bit({name, " fault"}, 1'b0, fault);
        check_xlen(name, model_load(op, a), res);
    endtask

    task automatic fault_check(input string name, input logic is_wr, input memop_t op,
                               input xlen_t a);
        xlen_t res;
        logic fault;
        do_access(is_wr, op, a, {$urandom(), $urandom()}, res, fault);
        faults_tally++;
        check_bit(name, 1'b1, fault);
    endtask

    task automatic cfg_write(input cfg_addr_t a, input cnt_t d);
        @(negedge clk);
        cfg_wr = 1'b1;
        cfg_addr = a;
        cfg_wdata = d;
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    task automatic cfg_check(input string name, input cfg_addr_t a, input cnt_t exp);
        @(negedge clk);
        cfg_addr = a;
        @(posedge clk);
        check_cnt(name, exp, cfg_rdata);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic test_sd_ld();
        xlen_t a [8];
        int e;
        e = errors;
        for (int i = 0; i < 8; i++) begin
            a[i] = xlen_t'($urandom_range(0, WORDS - 1)) << 3;
            store("sd random", MEMOP_LD, a[i], {$urandom(), $urandom()});
        end
        for (int i = 0; i < 8; i++) load_check($sformatf("ld %h", a[i]), MEMOP_LD, a[i]);
        report_test("sd_ld", e);
    endtask

    task automatic test_sub_word_stores();
        xlen_t base;
        int e;
        e = errors;
        base = 64'h100;
        store("sd fill", MEMOP_LD, base, {$urandom(), $urandom()});
        for (int op = 0; op < 3; op++) begin
            for (int off = 0; off < 8; off += (1 << op)) begin
                store("sub-word store", memop_t'(op), base + off, {$urandom(), $urandom()});
                load_check($sformatf("ld after op %0d +%0d", op, off), MEMOP_LD, base);
            end
        end
        report_test("sub_word_stores", e);
    endtask

    task automatic test_load_ext();
        xlen_t base;
        int e;
        e = errors;
        base = 64'h200;
        // every byte, half and word has its top bit set
        store("sd pattern", MEMOP_LD, base, 64'hF1E2_D3C4_B5A6_9788);
        for (int off = 0; off < 8; off++) begin
            load_check($sformatf("lb +%0d", off), MEMOP_LB, base + off);
            load_check($sformatf("lbu +%0d", off), MEMOP_LBU, base + off);
        end
        for (int off = 0; off < 8; off += 2) begin
            load_check($sformatf("lh +%0d", off), MEMOP_LH, base + off);
            load_check($sformatf("lhu +%0d", off), MEMOP_LHU, base + off);
        end
        for (int off = 0; off < 8; off += 4) begin
            load_check($sformatf("lw +%0d", off), MEMOP_LW, base + off);
            load_check($sformatf("lwu +%0d", off), MEMOP_LWU, base + off);
        end
        report_test("load_ext", e);
    endtask

    task automatic test_misaligned();
        xlen_t base;
        int e;
        e = errors;
        base = 64'h300;
        store("sd fill", MEMOP_LD, base, {$urandom(), $urandom()});
        fault_check("lh +1", 1'b0, MEMOP_LH, base + 1);
        fault_check("lw +2", 1'b0, MEMOP_LW, base + 2);
        fault_check("ld +4", 1'b0, MEMOP_LD, base + 4);
        fault_check("sh +3", 1'b1, MEMOP_LH, base + 3);
        fault_check("sw +1", 1'b1, MEMOP_LW, base + 1);
        fault_check("sd +5", 1'b1, MEMOP_LD, base + 5);
        load_check("ld after faults", MEMOP_LD, base);
        report_test("misaligned", e);
    endtask

    task automatic test_cfg_regs();
        int e;
        e = errors;
        cfg_check("lat after reset", REG_LAT, cnt_t'(`LAT_RESET));
        cfg_write(REG_LAT, 0);
        cfg_check("lat 0", REG_LAT, 0);
        store("sd lat 0", MEMOP_LD, 64'h400, {$urandom(), $urandom()});
        load_check("ld lat 0", MEMOP_LD, 64'h400);
        cfg_write(REG_LAT, 7);
        cfg_check("lat 7", REG_LAT, 7);
        store("sd lat 7", MEMOP_LD, 64'h408, {$urandom(), $urandom()});
        load_check("ld lat 7", MEMOP_LD, 64'h408);
        cfg_check("loads", REG_LOADS, cnt_t'(loads_tally));
        cfg_check("stores", REG_STORES, cnt_t'(stores_tally));
        cfg_check("faults", REG_FAULTS, cnt_t'(faults_tally));
        for (int r = 1; r < 4; r++) begin
            cfg_write(cfg_addr_t'(r), '1);
            cfg_check($sformatf("counter %0d cleared", r), cfg_addr_t'(r), 0);
        end
        report_test("cfg_regs", e);
    endtask

    // run limit counted in clock cycles
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run went past %0d cycles", MAX_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rden = 1'b0;
        wren = 1'b0;
        memop = MEMOP_LB;
        addr = '0;
        wr_data = '0;
        cfg_wr = 1'b0;
        cfg_addr = REG_LAT;
        cfg_wdata = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        loads_tally = 0;
        stores_tally = 0;
        faults_tally = 0;
        void'($urandom(54901));
        @(posedge rst_n);
        test_sd_ld();
        test_sub_word_stores();
        test_load_ext();
        test_misaligned();
        test_cfg_regs();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lsu_mem.f
+incdir+include
design/lsu_mem_pkg.sv
design/lsu.sv
design/data_sram.sv
design/mem_ctrl_regs.sv
design/lsu_mem_top.sv
verification/clk_gen.sv
verification/tb_lsu_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f lsu_mem.f --top-module tb_lsu_mem \
    -Mdir obj_dir -o tb_lsu_mem \
    && ./obj_dir/tb_lsu_mem | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "RESULT: PASS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
